// File: Makefile
# Verilator build and run of the receiver testbench

VERILATOR ?= verilator
TOP       ?= erx_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= sim passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: hdl/emesh_pkg.sv
`include "erx_settings.svh"

package emesh_pkg;

  // ####################
  // Packet fields
  // ####################

  // Decoded view, msb first
  // Bit 0 is a spare slot below the write flag
  typedef struct packed {
    // Return address for reads
    logic [31:0] srcaddr;
    // Write data or read-response data
    logic [31:0] data;
    // Target address, [31:20] is the link/core id
    logic [31:0] dstaddr;
    // Transaction qualifiers
    logic [3:0]  ctrlmode;
    // Transfer size code
    logic [1:0]  datamode;
    // High for writes and read responses
    logic        write;
    // Unused
    logic        spare;
  } emesh_fields_t;

  // ####################
  // Packet word
  // ####################

  // Same 104 bits, seen raw or as fields
  // Ports move the raw word, logic picks fields
  typedef union packed {
    logic [`ERX_PW-1:0] raw;
    emesh_fields_t      fields;
  } emesh_packet_u;

endpackage

// File: hdl/erx_disty.sv
`timescale 1ns/1ps

module erx_disty (
  // Stage outputs
  input  erx_pkg::erx_src_t  mmu_out,
  input  erx_pkg::erx_src_t  rr_out,
  // Local sources, combinational path
  input  erx_pkg::erx_src_t  dma_in,
  input  erx_pkg::erx_src_t  cfg_in,
  // FIFO back-pressure
  input  logic               wr_fifo_wait,
  input  logic               rd_fifo_wait,
  input  logic               rr_fifo_wait,
  // FIFO write ports
  output erx_pkg::erx_fifo_t wr_fifo,
  output erx_pkg::erx_fifo_t rd_fifo,
  output erx_pkg::erx_fifo_t rr_fifo,
  // Source waits
  output logic               link_rd_wait,
  output logic               link_wr_wait,
  output logic               dma_wait,
  output logic               cfg_wait
);

  logic mmu_write;
  logic mmu_read;

  // Split translated traffic by direction
  assign mmu_write = mmu_out.access & mmu_out.packet.fields.write;
  assign mmu_read  = mmu_out.access & ~mmu_out.packet.fields.write;

  // ####################
  // Write path
  // ####################

  // Translated writes only
  assign wr_fifo.access = mmu_write;
  assign wr_fifo.packet = mmu_out.packet;

  // ####################
  // Read path
  // ####################

  // Translated read first, DMA fills gaps
  assign rd_fifo.access = mmu_read | dma_in.access;
  assign rd_fifo.packet = mmu_read ? mmu_out.packet : dma_in.packet;

  // ####################
  // Read responses
  // ####################

  // rr_out already holds timeout over link priority
  assign rr_fifo.access = rr_out.access | cfg_in.access;
  assign rr_fifo.packet = rr_out.access ? rr_out.packet : cfg_in.packet;

  // ####################
  // Waits
  // ####################

  assign link_rd_wait = rd_fifo_wait;
  // Link writes may target either the write or response FIFO
  assign link_wr_wait = wr_fifo_wait | rr_fifo_wait;
  // DMA loses to a pending mmu read
  assign dma_wait     = mmu_read | rd_fifo_wait;
  // cfg loses to any response stage output
  assign cfg_wait     = rr_out.access | rr_fifo_wait;

endmodule

// File: hdl/erx_mmu.sv
`timescale 1ns/1ps

`include "erx_settings.svh"

module erx_mmu (
  input  logic                  clk,
  input  logic                  arst_n,
  // Mesh side packets to translate
  input  erx_pkg::erx_src_t     mmu_in,
  // Table write port
  input  erx_pkg::erx_mmu_wr_t  mmu_wr,
  // Target FIFO waits
  input  logic                  wr_fifo_wait,
  input  logic                  rd_fifo_wait,
  // Registered, translated packet
  output erx_pkg::erx_src_t     mmu_out
);

  // Index width follows the table size
  localparam int IW = $clog2(`ERX_MMU_ENTRIES);

  // ####################
  // Remap table
  // ####################

  logic [`ERX_MMU_ENTRIES-1:0] tbl_valid;
  logic [11:0]                 tbl_base [`ERX_MMU_ENTRIES];

  // Entry state, all invalid after reset
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      tbl_valid <= '0;
    end else if (mmu_wr.en) begin
      tbl_valid[mmu_wr.idx[IW-1:0]] <= mmu_wr.valid;
    end
  end

  // Base values
  always_ff @(posedge clk) begin
    if (mmu_wr.en) begin
      tbl_base[mmu_wr.idx[IW-1:0]] <= mmu_wr.base;
    end
  end

  // ####################
  // Lookup
  // ####################

  logic [IW-1:0]            in_idx;
  emesh_pkg::emesh_packet_u xlat_pkt;

  // Top address bits pick the entry
  assign in_idx = mmu_in.packet.fields.dstaddr[31 -: IW];

  always_comb begin
    xlat_pkt = mmu_in.packet;
    // Valid entry swaps the id field, else identity
    if (tbl_valid[in_idx]) begin
      xlat_pkt.fields.dstaddr[31:20] = tbl_base[in_idx];
    end
  end

  // ####################
  // Stage register
  // ####################

  logic                     stage_access;
  emesh_pkg::emesh_packet_u stage_pkt;
  logic                     stage_hold;
  logic                     in_wait;

  // Held packet waits on the FIFO its write flag selects
  assign stage_hold = stage_access &
                      (stage_pkt.fields.write ? wr_fifo_wait : rd_fifo_wait);

  // Incoming packet is only taken if its own FIFO is free
  assign in_wait = mmu_in.packet.fields.write ? wr_fifo_wait : rd_fifo_wait;

  // Access strobe
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      stage_access <= 1'b0;
    end else if (!stage_hold) begin
      stage_access <= mmu_in.access & ~in_wait;
    end
  end

  // Payload, no reset
  always_ff @(posedge clk) begin
    if (!stage_hold && mmu_in.access && !in_wait) begin
      stage_pkt <= xlat_pkt;
    end
  end

  assign mmu_out.access = stage_access;
  assign mmu_out.packet = stage_pkt;

endmodule

// File: hdl/erx_pkg.sv
package erx_pkg;

  // ####################
  // Packet sources
  // ####################

  // One-cycle access strobe with its packet
  // Packet stays put while the source sees its wait high
  typedef struct packed {
    logic                    access;
    emesh_pkg::emesh_packet_u packet;
  } erx_src_t;

  // ####################
  // FIFO write ports
  // ####################

  // Taken by the FIFO when access is high and its wait is low
  typedef struct packed {
    logic                    access;
    emesh_pkg::emesh_packet_u packet;
  } erx_fifo_t;

  // ####################
  // Remap table writes
  // ####################

  // One entry per strobe
  typedef struct packed {
    logic        en;
    logic [3:0]  idx;
    logic        valid;
    logic [11:0] base;
  } erx_mmu_wr_t;

endpackage

// File: hdl/erx_rr_path.sv
`timescale 1ns/1ps

`include "erx_settings.svh"

module erx_rr_path (
  input  logic              clk,
  input  logic              arst_n,
  // Raw link traffic, bypasses translation
  input  erx_pkg::erx_src_t link_in,
  // Timeout strobe from the read timer
  input  logic              timeout,
  input  logic              rr_fifo_wait,
  // Registered read response, timeout merged in
  output erx_pkg::erx_src_t rr_out
);

  // ####################
  // Response detect
  // ####################

  logic link_rr;

  // Write to our id in the read-response region
  assign link_rr = link_in.access &
                   link_in.packet.fields.write &
                   (link_in.packet.fields.dstaddr[31:20] == `ERX_ID) &
                   (link_in.packet.fields.dstaddr[19:16] == `ERX_RR_TAG);

  // ####################
  // Timeout response
  // ####################

  emesh_pkg::emesh_packet_u tmo_pkt;

  always_comb begin
    tmo_pkt                 = '0;
    tmo_pkt.fields.write    = 1'b1;
    tmo_pkt.fields.datamode = 2'b01;
    // Own id, region F, zero offset
    tmo_pkt.fields.dstaddr  = {`ERX_ID, 4'hF, 16'h0000};
    // Marker value for a lost read
    tmo_pkt.fields.data     = 32'hDEADBEEF;
  end

  // ####################
  // Stage register
  // ####################

  logic                     rr_access;
  emesh_pkg::emesh_packet_u rr_pkt;

  // Nothing moves while the response FIFO waits
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rr_access <= 1'b0;
    end else if (!rr_fifo_wait) begin
      rr_access <= timeout | link_rr;
    end
  end

  // Timeout wins a same-cycle tie
  always_ff @(posedge clk) begin
    if (!rr_fifo_wait) begin
      if (timeout) begin
        rr_pkt <= tmo_pkt;
      end else if (link_rr) begin
        rr_pkt <= link_in.packet;
      end
    end
  end

  assign rr_out.access = rr_access;
  assign rr_out.packet = rr_pkt;

endmodule

// File: hdl/erx_settings.svh
`ifndef ERX_SETTINGS_SVH
`define ERX_SETTINGS_SVH

// ####################
// Receiver identity
// ####################

// Link id, compared with dstaddr[31:20]
`define ERX_ID 12'h800

// Region code of a read response, in dstaddr[19:16]
`define ERX_RR_TAG 4'hD

// ####################
// Sizing
// ####################

// Remap entries, indexed from dstaddr[31:28] downward
`define ERX_MMU_ENTRIES 16

// Emesh packet width
`define ERX_PW 104

`endif

// File: hdl/erx_top.sv
`timescale 1ns/1ps

module erx_top (
  input  logic                 clk,
  input  logic                 arst_n,
  // Packet sources
  input  erx_pkg::erx_src_t    link_in,
  input  erx_pkg::erx_src_t    mmu_in,
  input  erx_pkg::erx_src_t    dma_in,
  input  erx_pkg::erx_src_t    cfg_in,
  // Read timer strobe
  input  logic                 timeout,
  // Remap table writes
  input  erx_pkg::erx_mmu_wr_t mmu_wr,
  // FIFO back-pressure
  input  logic                 wr_fifo_wait,
  input  logic                 rd_fifo_wait,
  input  logic                 rr_fifo_wait,
  // FIFO write ports
  output erx_pkg::erx_fifo_t   wr_fifo,
  output erx_pkg::erx_fifo_t   rd_fifo,
  output erx_pkg::erx_fifo_t   rr_fifo,
  // Source waits
  output logic                 link_rd_wait,
  output logic                 link_wr_wait,
  output logic                 dma_wait,
  output logic                 cfg_wait
);

  // Stage outputs into the distributor
  erx_pkg::erx_src_t mmu_out;
  erx_pkg::erx_src_t rr_out;

  // ####################
  // Address translation
  // ####################

  erx_mmu i_erx_mmu (
    .clk          (clk),
    .arst_n       (arst_n),
    .mmu_in       (mmu_in),
    .mmu_wr       (mmu_wr),
    .wr_fifo_wait (wr_fifo_wait),
    .rd_fifo_wait (rd_fifo_wait),
    .mmu_out      (mmu_out)
  );

  // ####################
  // Read-response bypass
  // ####################

  erx_rr_path i_erx_rr_path (
    .clk          (clk),
    .arst_n       (arst_n),
    .link_in      (link_in),
    .timeout      (timeout),
    .rr_fifo_wait (rr_fifo_wait),
    .rr_out       (rr_out)
  );

  // ####################
  // Distribution
  // ####################

  erx_disty i_erx_disty (
    .mmu_out      (mmu_out),
    .rr_out       (rr_out),
    .dma_in       (dma_in),
    .cfg_in       (cfg_in),
    .wr_fifo_wait (wr_fifo_wait),
    .rd_fifo_wait (rd_fifo_wait),
    .rr_fifo_wait (rr_fifo_wait),
    .wr_fifo      (wr_fifo),
    .rd_fifo      (rd_fifo),
    .rr_fifo      (rr_fifo),
    .link_rd_wait (link_rd_wait),
    .link_wr_wait (link_wr_wait),
    .dma_wait     (dma_wait),
    .cfg_wait     (cfg_wait)
  );

endmodule

// File: tests/erx_tb.sv
`timescale 1ns/1ps

`include "erx_settings.svh"

module erx_tb;

  // Random back-pressure phase
  localparam int BP_CYCLES  = 300;
  // Reset, remap, read merge, link responses, timeout, back-pressure, drains
  localparam int RUN_CYCLES = 6 + 52 + 16 + 12 + 12 + BP_CYCLES + 10;

  // Expected FIFO ports and waits for one cycle
  typedef struct packed {
    erx_pkg::erx_fifo_t wr;
    erx_pkg::erx_fifo_t rd;
    erx_pkg::erx_fifo_t rr;
    logic               link_rd_wait;
    logic               link_wr_wait;
    logic               dma_wait;
    logic               cfg_wait;
  } expect_t;

  logic                 clk;
  logic                 arst_n;
  erx_pkg::erx_src_t    link_in;
  erx_pkg::erx_src_t    mmu_in;
  erx_pkg::erx_src_t    dma_in;
  erx_pkg::erx_src_t    cfg_in;
  logic                 timeout;
  erx_pkg::erx_mmu_wr_t mmu_wr;
  logic                 wr_fifo_wait;
  logic                 rd_fifo_wait;
  logic                 rr_fifo_wait;
  erx_pkg::erx_fifo_t   wr_fifo;
  erx_pkg::erx_fifo_t   rd_fifo;
  erx_pkg::erx_fifo_t   rr_fifo;
  logic                 link_rd_wait;
  logic                 link_wr_wait;
  logic                 dma_wait;
  logic                 cfg_wait;

  // Reference remap table and stage contents
  logic [`ERX_MMU_ENTRIES-1:0] ref_valid;
  logic [11:0]                 ref_base [`ERX_MMU_ENTRIES];
  erx_pkg::erx_src_t           ref_mmu;
  erx_pkg::erx_src_t           ref_rr;
  // Sources whose packet went in at the last edge
  logic                        mmu_taken;
  logic                        link_taken;
  logic                        dma_taken;
  logic                        cfg_taken;

  int     errors;
  int     test_errors;
  int     tests;
  int     taken;
  int     accepted;
  integer seed;

  erx_top i_erx_top (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Hard stop in case a handshake never completes
  initial begin
    #((RUN_CYCLES + 100) * 20);
    $display("Watchdog expired before all tests finished");
    $display("sim failed");
    $finish;
  end

  // ####################
  // Reference model
  // ####################

  function automatic emesh_pkg::emesh_packet_u rand_packet(input logic       write,
                                                           input logic [3:0] top);
    emesh_pkg::emesh_packet_u p;
    logic [31:0]              r0;
    logic [31:0]              r1;
    logic [31:0]              r2;
    logic [31:0]              r3;
    r0 = $random(seed);
    r1 = $random(seed);
    r2 = $random(seed);
    r3 = $random(seed);
    p.raw = {r0, r1, r2, r3[7:0]};
    p.fields.write = write;
    // Top nibble picks the remap entry
    p.fields.dstaddr[31:28] = top;
    return p;
  endfunction

  // Write to this link in the response region
  function automatic emesh_pkg::emesh_packet_u response_packet();
    emesh_pkg::emesh_packet_u p;
    p = rand_packet(1'b1, 4'h0);
    p.fields.dstaddr[31:16] = {`ERX_ID, `ERX_RR_TAG};
    return p;
  endfunction

  function automatic emesh_pkg::emesh_packet_u timeout_packet();
    emesh_pkg::emesh_packet_u p;
    p = '0;
    p.fields.write = 1'b1;
    p.fields.datamode = 2'b01;
    p.fields.dstaddr = {`ERX_ID, 4'hF, 16'h0000};
    p.fields.data = 32'hDEADBEEF;
    return p;
  endfunction

  function automatic emesh_pkg::emesh_packet_u translate(input emesh_pkg::emesh_packet_u p);
    logic [3:0] idx;
    idx = p.fields.dstaddr[31:28];
    if (ref_valid[idx]) begin
      p.fields.dstaddr[31:20] = ref_base[idx];
    end
    return p;
  endfunction

  function automatic logic is_response();
    return link_in.access && link_in.packet.fields.write &&
           link_in.packet.fields.dstaddr[31:16] == {`ERX_ID, `ERX_RR_TAG};
  endfunction

  // Outputs from the modeled stages and the live local sources
  function automatic expect_t erx_expect();
    expect_t e;
    logic    mmu_rd;
    mmu_rd = ref_mmu.access & ~ref_mmu.packet.fields.write;
    e.wr.access = ref_mmu.access & ref_mmu.packet.fields.write;
    e.wr.packet = ref_mmu.packet;
    // Translated read over DMA
    e.rd.access = mmu_rd | dma_in.access;
    e.rd.packet = mmu_rd ? ref_mmu.packet : dma_in.packet;
    // Stage response over cfg
    e.rr.access = ref_rr.access | cfg_in.access;
    e.rr.packet = ref_rr.access ? ref_rr.packet : cfg_in.packet;
    e.link_rd_wait = rd_fifo_wait;
    e.link_wr_wait = wr_fifo_wait | rr_fifo_wait;
    e.dma_wait = mmu_rd | rd_fifo_wait;
    e.cfg_wait = ref_rr.access | rr_fifo_wait;
    return e;
  endfunction

  // ####################
  // Checks
  // ####################

  task automatic check_port(input string name, input erx_pkg::erx_fifo_t exp, act);
    // Packet only matters while access is high
    assert (exp.access ? (act === exp) : (act.access === 1'b0)) else begin
      $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
      errors++;
      test_errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    assert (act === exp) else begin
      $display("[FAIL] %0t %s expected %b got %b", $time, name, exp, act);
      errors++;
      test_errors++;
    end
  endtask

  always @(posedge clk) begin
    expect_t e;
    logic    hold;
    logic    in_wait;
    logic    link_rr;
    if (!arst_n) begin
      ref_valid = '0;
      ref_mmu.access = 1'b0;
      ref_rr.access = 1'b0;
      mmu_taken = 1'b0;
      link_taken = 1'b0;
      dma_taken = 1'b0;
      cfg_taken = 1'b0;
    end else begin
      e = erx_expect();
      check_port("wr_fifo", e.wr, wr_fifo);
      check_port("rd_fifo", e.rd, rd_fifo);
      check_port("rr_fifo", e.rr, rr_fifo);
      check_bit("link_rd_wait", e.link_rd_wait, link_rd_wait);
      check_bit("link_wr_wait", e.link_wr_wait, link_wr_wait);
      check_bit("dma_wait", e.dma_wait, dma_wait);
      check_bit("cfg_wait", e.cfg_wait, cfg_wait);
      accepted = accepted + int'(wr_fifo.access & ~wr_fifo_wait) +
                 int'(rd_fifo.access & ~rd_fifo_wait) + int'(rr_fifo.access & ~rr_fifo_wait);
      // Local sources let go once the DUT drops their wait
      dma_taken = dma_in.access & ~dma_wait;
      cfg_taken = cfg_in.access & ~cfg_wait;
      // Translation stage, blocked by its held or its new target
      hold = ref_mmu.access & (ref_mmu.packet.fields.write ? wr_fifo_wait : rd_fifo_wait);
      in_wait = mmu_in.packet.fields.write ? wr_fifo_wait : rd_fifo_wait;
      mmu_taken = mmu_in.access & ~hold & ~in_wait;
      if (!hold) begin
        ref_mmu.access = mmu_taken;
        if (mmu_taken) begin
          ref_mmu.packet = translate(mmu_in.packet);
        end
      end
      // Response stage, timeout first
      link_rr = is_response();
      link_taken = link_in.access & ~rr_fifo_wait & ~timeout;
      if (!rr_fifo_wait) begin
        ref_rr.access = timeout | link_rr;
        if (timeout) begin
          ref_rr.packet = timeout_packet();
        end else if (link_rr) begin
          ref_rr.packet = link_in.packet;
        end
      end
      taken = taken + int'(mmu_taken) + int'(link_taken & link_rr) +
              int'(timeout & ~rr_fifo_wait) + int'(dma_taken) + int'(cfg_taken);
      // Table write lands after this edge's lookup
      if (mmu_wr.en) begin
        ref_valid[mmu_wr.idx] = mmu_wr.valid;
        ref_base[mmu_wr.idx] = mmu_wr.base;
      end
    end
  end

  // ####################
  // Stimulus
  // ####################

  // Step one cycle, sources drop what went in, strobes end
  task automatic next_cycle();
    @(negedge clk);
    if (mmu_taken) begin
      mmu_in.access = 1'b0;
    end
    if (link_taken) begin
      link_in.access = 1'b0;
    end
    if (dma_taken) begin
      dma_in.access = 1'b0;
    end
    if (cfg_taken) begin
      cfg_in.access = 1'b0;
    end
    timeout = 1'b0;
    mmu_wr.en = 1'b0;
  endtask

  task automatic push_mmu(input emesh_pkg::emesh_packet_u p);
    mmu_in.access = 1'b1;
    mmu_in.packet = p;
    do begin
      next_cycle();
    end while (mmu_in.access);
  endtask

  // Drain, then compare packets in against packets out
  task automatic end_test(input string name);
    wr_fifo_wait = 1'b0;
    rd_fifo_wait = 1'b0;
    rr_fifo_wait = 1'b0;
    repeat (3) next_cycle();
    assert (taken == accepted) else begin
      $display("Packets lost or repeated in %s: %0d taken, %0d accepted", name, taken, accepted);
      errors++;
      test_errors++;
    end
    if (test_errors == 0) begin
      $display("%s: ok, 0 errors", name);
    end else begin
      $display("%s: FAILED, %0d errors", name, test_errors);
    end
    tests++;
    test_errors = 0;
  endtask

  initial begin
    logic [31:0] r;
    seed = 32'hceefdd29;
    errors = 0;
    test_errors = 0;
    tests = 0;
    taken = 0;
    accepted = 0;
    arst_n = 1'b0;
    link_in = '0;
    mmu_in = '0;
    dma_in = '0;
    cfg_in = '0;
    timeout = 1'b0;
    mmu_wr = '0;
    wr_fifo_wait = 1'b0;
    rd_fifo_wait = 1'b0;
    rr_fifo_wait = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    // Identity after reset, then odd entries valid
    for (int i = 0; i < 16; i++) begin
      push_mmu(rand_packet(1'b1, 4'(i)));
    end
    for (int i = 0; i < 16; i++) begin
      mmu_wr.en = 1'b1;
      mmu_wr.idx = 4'(i);
      mmu_wr.valid = i[0];
      mmu_wr.base = 12'($random(seed));
      next_cycle();
    end
    for (int i = 0; i < 16; i++) begin
      push_mmu(rand_packet(1'b1, 4'(i)));
    end
    end_test("remap table");

    // DMA arrives while the translated read sits in the stage
    for (int i = 0; i < 4; i++) begin
      mmu_in.access = 1'b1;
      mmu_in.packet = rand_packet(1'b0, 4'(i));
      next_cycle();
      dma_in.access = 1'b1;
      dma_in.packet = rand_packet(1'b0, 4'(i + 8));
      do begin
        next_cycle();
      end while (dma_in.access);
    end
    end_test("read merge");

    // Matching and non-matching link traffic alternate
    for (int i = 0; i < 8; i++) begin
      link_in.access = 1'b1;
      link_in.packet = i[0] ? response_packet() : rand_packet(1'b1, 4'h2);
      do begin
        next_cycle();
      end while (link_in.access);
    end
    end_test("link responses");

    // Timeout beside a link response, cfg behind both
    for (int i = 0; i < 2; i++) begin
      timeout = 1'b1;
      link_in.access = 1'b1;
      link_in.packet = response_packet();
      next_cycle();
      cfg_in.access = 1'b1;
      cfg_in.packet = rand_packet(1'b1, 4'h4);
      do begin
        next_cycle();
      end while (link_in.access || cfg_in.access);
    end
    end_test("timeout priority");

    // FIFO waits change every 4 cycles
    for (int c = 0; c < BP_CYCLES; c++) begin
      r = $random(seed);
      if (c % 4 == 0) begin
        wr_fifo_wait = r[0] & r[1];
        rd_fifo_wait = r[2] & r[11];
        rr_fifo_wait = r[12] & r[13];
      end
      if (!mmu_in.access && r[3]) begin
        mmu_in.access = 1'b1;
        mmu_in.packet = rand_packet(r[4], r[8:5]);
      end
      if (!link_in.access && r[9]) begin
        link_in.access = 1'b1;
        link_in.packet = r[10] ? response_packet() : rand_packet(1'b1, 4'h2);
      end
      next_cycle();
    end
    wr_fifo_wait = 1'b0;
    rd_fifo_wait = 1'b0;
    rr_fifo_wait = 1'b0;
    while (mmu_in.access || link_in.access) begin
      next_cycle();
    end
    end_test("back-pressure");

    $display("%0d tests, %0d errors", tests, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+hdl
hdl/emesh_pkg.sv
hdl/erx_pkg.sv
hdl/erx_mmu.sv
hdl/erx_rr_path.sv
hdl/erx_disty.sv
hdl/erx_top.sv
tests/erx_tb.sv
